/* prog.hex */
// one 64-bit word per line, word index is byte address / 8
// low half is the instruction at pc, high half the one at pc + 4
06400113123450b7 // 0x00 lui x1 ; 0x04 addi x2,x0,100
40218233002081b3 // 0x08 add x3 ; 0x0c sub x4
0020e3330021f2b3 // 0x10 and x5 ; 0x14 or x6
00112433003343b3 // 0x18 xor x7 ; 0x1c slt x8
002004b300500013 // 0x20 addi x0 ; 0x24 add x9,x0,x2
0010051300248463 // 0x28 beq taken ; 0x2c wrong path
ff90059300249463 // 0x30 bne not taken ; 0x34 addi x11,-7
1000360310b03023 // 0x38 sd x11,0x100 ; 0x3c ld x12,0x100
00200513008006ef // 0x40 jal x13,+8 ; 0x44 wrong path
0000006f00d60733 // 0x48 add x14 ; 0x4c jal x0,0
@20
0123456789abcdef // data word at byte 0x100

/* src.f */
cpu_pkg.sv
cpu_regfile.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_lsu_wb.sv
cpu_mem_arbiter.sv
cpu_sram.sv
cpu_top.sv
tb_cpu.sv

/* tb_cpu.sv */
module tb_cpu;
	import cpu_pkg::*;

	//**********************************************************************
	// run length
	//**********************************************************************

	localparam int reset_cycles = 10;
	// 18 program instructions plus two turns of the final jal loop
	localparam int retire_total = 20;
	// shared memory port, so a generous budget per instruction
	localparam int timeout_cycles = reset_cycles + retire_total * 12;
	localparam time drive_delay = 5;

	logic            clk;
	logic            reset;
	logic [xlen-1:0] pc;
	retire_t         retire;

	// reference isa state
	logic [xlen-1:0] m_regs [32];
	logic [xlen-1:0] m_mem [mem_words];
	logic [xlen-1:0] m_pc;
	int              retired;

	// prediction for the next retire
	logic [xlen-1:0] exp_pc;
	logic [4:0]      exp_rd;
	logic            exp_wen;
	logic [xlen-1:0] exp_wdata;
	logic [xlen-1:0] next_pc;
	// pending store of the predicted instruction
	logic            st_en;
	logic [xlen-1:0] st_addr;
	logic [xlen-1:0] st_data;

	cpu_top i_dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.retire(retire)
	);

	// 40 unit period
	always #20 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string name, input logic [xlen-1:0] exp,
		input logic [xlen-1:0] act);
		stop_with_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	//**********************************************************************
	// reference model of the rv64 subset
	//**********************************************************************

	function automatic logic [xlen-1:0] reg_read(input logic [4:0] r);
		return (r == 5'd0) ? '0 : m_regs[r];
	endfunction

	function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b, input logic sub);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'b100:  return a ^ b;
			3'b110:  return a | b;
			3'b111:  return a & b;
			default: return '0;
		endcase
	endfunction

	// expected retire record of the instruction at m_pc
	task automatic predict();
		logic [31:0]     ins;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] imm_s;
		logic [xlen-1:0] imm_b;
		logic [xlen-1:0] imm_j;
		logic [xlen-1:0] addr;
		// low half of the word at pc bit 2 clear
		ins = m_pc[2] ? m_mem[m_pc[mem_aw+2:3]][63:32] : m_mem[m_pc[mem_aw+2:3]][31:0];
		a = reg_read(ins[19:15]);
		b = reg_read(ins[24:20]);
		imm_i = {{52{ins[31]}}, ins[31:20]};
		imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		exp_pc = m_pc;
		exp_rd = ins[11:7];
		exp_wen = 1'b0;
		exp_wdata = '0;
		next_pc = m_pc + 64'd4;
		st_en = 1'b0;
		st_addr = '0;
		st_data = '0;
		case (ins[6:0])
			opc_lui: begin
				exp_wen = 1'b1;
				exp_wdata = {{32{ins[31]}}, ins[31:12], 12'b0};
			end
			opc_op_imm: begin
				exp_wen = 1'b1;
				exp_wdata = alu_ref(ins[14:12], a, imm_i, 1'b0);
			end
			opc_op: begin
				exp_wen = 1'b1;
				exp_wdata = alu_ref(ins[14:12], a, b, ins[30]);
			end
			opc_branch: begin
				// beq on funct3 bit 0 clear, bne on set
				if ((a == b) != ins[12]) begin
					next_pc = m_pc + imm_b;
				end
			end
			opc_jal: begin
				exp_wen = 1'b1;
				exp_wdata = m_pc + 64'd4;
				next_pc = m_pc + imm_j;
			end
			opc_load: begin
				addr = a + imm_i;
				exp_wen = 1'b1;
				exp_wdata = m_mem[addr[mem_aw+2:3]];
			end
			opc_store: begin
				st_en = 1'b1;
				st_addr = a + imm_s;
				st_data = b;
			end
			default: ;
		endcase
		// x0 target retires without a write
		if (exp_rd == 5'd0) begin
			exp_wen = 1'b0;
		end
	endtask

	// one model step per retire
	always @(posedge clk) begin
		if (!reset && retire.valid === 1'b1) begin
			if (exp_wen) begin
				m_regs[exp_rd] = exp_wdata;
			end
			if (st_en) begin
				m_mem[st_addr[mem_aw+2:3]] = st_data;
			end
			m_pc = next_pc;
			retired = retired + 1;
			predict();
		end
	end

	//**********************************************************************
	// retire checks
	//**********************************************************************

	reset_quiet: assert property (@(posedge clk) reset |-> !retire.valid)
		else report_mismatch("reset_quiet", 64'd0, {63'b0, $sampled(retire.valid)});

	// fetch pc right after reset
	fetch_start_pc: assert property (@(posedge clk) $fell(reset) |-> pc == reset_pc)
		else report_mismatch("fetch_start_pc", reset_pc, $sampled(pc));

	retire_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(retire.valid))
		else stop_with_error("retire valid is unknown after reset");

	first_pc: assert property (@(posedge clk) disable iff (reset)
		(retire.valid && retired == 0) |-> retire.pc == reset_pc)
		else report_mismatch("first_pc", reset_pc, $sampled(retire.pc));

	// also catches any wrong-path retire
	pc_sequence: assert property (@(posedge clk) disable iff (reset)
		retire.valid |-> retire.pc == exp_pc)
		else report_mismatch("pc_sequence", $sampled(exp_pc), $sampled(retire.pc));

	// stores, branches and x0 targets low
	write_enable: assert property (@(posedge clk) disable iff (reset)
		retire.valid |-> retire.wen == exp_wen)
		else report_mismatch("write_enable", {63'b0, $sampled(exp_wen)},
			{63'b0, $sampled(retire.wen)});

	dest_reg: assert property (@(posedge clk) disable iff (reset)
		(retire.valid && exp_wen) |-> retire.rd == exp_rd)
		else report_mismatch("dest_reg", 64'($sampled(exp_rd)), 64'($sampled(retire.rd)));

	write_data: assert property (@(posedge clk) disable iff (reset)
		(retire.valid && exp_wen) |-> retire.wdata == exp_wdata)
		else report_mismatch("write_data", $sampled(exp_wdata), $sampled(retire.wdata));

	x0_write: assert property (@(posedge clk) disable iff (reset)
		(retire.valid && retire.wen) |-> retire.rd != 5'd0)
		else stop_with_error("retire wrote register x0");

	//**********************************************************************
	// reset, run, verdict
	//**********************************************************************

	initial begin
		int cycles;
		cycles = reset_cycles;
		clk = 1'b0;
		reset = 1'b1;
		retired = 0;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		$readmemh("prog.hex", m_mem);
		m_pc = reset_pc;
		predict();
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		// sample the count away from the retire edge
		while (retired < retire_total && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (retired >= retire_total) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_with_error($sformatf("timeout, the pipeline stopped retiring after %0d of %0d",
				retired, retire_total));
		end
	end

endmodule

/* cpu_top.sv */
module cpu_top (
	input  logic                     clk,
	input  logic                     reset,
	output logic [cpu_pkg::xlen-1:0] pc,
	output cpu_pkg::retire_t         retire
);
	import cpu_pkg::*;

	// shared memory ports
	mem_req_t        f_req;
	mem_req_t        d_req;
	mem_req_t        m_req;
	mem_resp_t       f_resp;
	mem_resp_t       d_resp;
	mem_resp_t       m_resp;
	logic            f_grant;
	logic            d_grant;

	// stage links
	if_id_t          if_id;
	logic            if_id_valid;
	logic            if_id_ready;
	id_ex_t          id_ex;
	logic            id_ex_valid;
	logic            id_ex_ready;
	ex_mem_t         ex_mem;
	logic            ex_mem_valid;
	logic            ex_mem_ready;

	// branch redirect and register reads
	logic            redirect;
	logic [xlen-1:0] redirect_pc;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;

	//********************************************************************
	// pipeline
	//********************************************************************

	cpu_fetch i_fetch (
		.clk(clk), .reset(reset), .req(f_req), .resp(f_resp), .grant(f_grant),
		.redirect(redirect), .redirect_pc(redirect_pc), .out(if_id),
		.out_valid(if_id_valid), .out_ready(if_id_ready), .pc(pc)
	);

	cpu_decode i_decode (
		.clk(clk), .reset(reset), .in(if_id), .in_valid(if_id_valid),
		.in_ready(if_id_ready), .rs1(rs1), .rs2(rs2), .rdata1(rdata1),
		.rdata2(rdata2), .retire(retire), .flush(redirect), .out(id_ex),
		.out_valid(id_ex_valid), .out_ready(id_ex_ready)
	);

	cpu_regfile i_regfile (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rdata1(rdata1),
		.rdata2(rdata2), .wr(retire)
	);

	cpu_execute i_execute (
		.clk(clk), .reset(reset), .in(id_ex), .in_valid(id_ex_valid),
		.in_ready(id_ex_ready), .out(ex_mem), .out_valid(ex_mem_valid),
		.out_ready(ex_mem_ready), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	cpu_lsu_wb i_lsu_wb (
		.clk(clk), .reset(reset), .in(ex_mem), .in_valid(ex_mem_valid),
		.in_ready(ex_mem_ready), .req(d_req), .resp(d_resp), .grant(d_grant),
		.retire(retire)
	);

	//********************************************************************
	// memory side
	//********************************************************************

	cpu_mem_arbiter i_arbiter (
		.clk(clk), .reset(reset), .f_req(f_req), .f_resp(f_resp), .f_grant(f_grant),
		.d_req(d_req), .d_resp(d_resp), .d_grant(d_grant), .m_req(m_req),
		.m_resp(m_resp)
	);

	cpu_sram i_sram (
		.clk(clk), .reset(reset), .req(m_req), .resp(m_resp)
	);

endmodule

/* cpu_sram.sv */
module cpu_sram (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::mem_req_t  req,
	output cpu_pkg::mem_resp_t resp
);
	import cpu_pkg::*;

	logic [xlen-1:0] mem [mem_words];

	// program and data image
	initial begin
		$readmemh("prog.hex", mem);
	end

	// every request answered one cycle later, writes too
	always_ff @(posedge clk) begin
		if (reset) begin
			resp.valid <= 1'b0;
		end else begin
			resp.valid <= req.valid;
		end
		if (req.valid) begin
			if (req.write) begin
				mem[req.addr] <= req.wdata;
			end
			// old word on a write
			resp.rdata <= mem[req.addr];
		end
	end

endmodule

/* cpu_mem_arbiter.sv */
module cpu_mem_arbiter (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::mem_req_t  f_req,
	output cpu_pkg::mem_resp_t f_resp,
	output logic               f_grant,
	input  cpu_pkg::mem_req_t  d_req,
	output cpu_pkg::mem_resp_t d_resp,
	output logic               d_grant,
	output cpu_pkg::mem_req_t  m_req,
	input  cpu_pkg::mem_resp_t m_resp
);

	// 1 when the request in the sram came from the data port
	logic owner_q;

	//********************************************************************
	// fixed priority, data port first
	//********************************************************************

	assign d_grant = d_req.valid;
	assign f_grant = f_req.valid && !d_req.valid;
	// fetch request also goes through when idle, valid low then
	assign m_req = d_req.valid ? d_req : f_req;

	// sram answers one cycle later, remember who asked
	always_ff @(posedge clk) begin
		if (reset) begin
			owner_q <= 1'b0;
		end else begin
			owner_q <= d_req.valid;
		end
	end

	// response steering
	always_comb begin
		f_resp.valid = m_resp.valid && !owner_q;
		f_resp.rdata = m_resp.rdata;
		d_resp.valid = m_resp.valid && owner_q;
		d_resp.rdata = m_resp.rdata;
	end

endmodule

/* cpu_lsu_wb.sv */
module cpu_lsu_wb (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::ex_mem_t   in,
	input  logic               in_valid,
	output logic               in_ready,
	output cpu_pkg::mem_req_t  req,
	input  cpu_pkg::mem_resp_t resp,
	input  logic               grant,
	output cpu_pkg::retire_t   retire
);
	import cpu_pkg::*;

	ex_mem_t cur;
	logic    cur_valid;
	logic    is_mem;
	logic    done;
	logic    fire;

	assign is_mem = cur.is_load || cur.is_store;
	// alu ops finish at once, ld and sd on their response
	assign done = cur_valid && (!is_mem || resp.valid);
	assign in_ready = !cur_valid || done;
	assign fire = in_valid && in_ready;

	//********************************************************************
	// retire record, also the register write
	//********************************************************************

	always_comb begin
		retire.valid = done;
		retire.pc = cur.pc;
		retire.rd = cur.rd;
		retire.wdata = cur.is_load ? resp.rdata : cur.result;
		// stores and x0 targets carry wen low
		retire.wen = cur.writes_rd;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_valid <= 1'b0;
			req.valid <= 1'b0;
		end else begin
			if (fire) begin
				cur_valid <= 1'b1;
			end else if (done) begin
				cur_valid <= 1'b0;
			end
			// request held until the arbiter grants it
			if (req.valid && grant) begin
				req.valid <= 1'b0;
			end
			if (fire && (in.is_load || in.is_store)) begin
				req.valid <= 1'b1;
			end
		end
		if (fire) begin
			cur <= in;
			req.write <= in.is_store;
			// byte address to word index, aligned 64-bit only
			req.addr <= in.result[mem_aw+2:3];
			req.wdata <= in.store_data;
		end
	end

endmodule

/* cpu_execute.sv */
module cpu_execute (
	input  logic                     clk,
	input  logic                     reset,
	input  cpu_pkg::id_ex_t          in,
	input  logic                     in_valid,
	output logic                     in_ready,
	output cpu_pkg::ex_mem_t         out,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic                     redirect,
	output logic [cpu_pkg::xlen-1:0] redirect_pc
);
	import cpu_pkg::*;

	logic [xlen-1:0] alu;
	logic            taken;
	logic            taken_q;
	logic            fire;

	// alu, also the address adder for ld and sd
	always_comb begin
		case (in.alu_op)
			alu_add:    alu = in.op_a + in.op_b;
			alu_sub:    alu = in.op_a - in.op_b;
			alu_and:    alu = in.op_a & in.op_b;
			alu_or:     alu = in.op_a | in.op_b;
			alu_xor:    alu = in.op_a ^ in.op_b;
			alu_slt:    alu = {63'b0, $signed(in.op_a) < $signed(in.op_b)};
			alu_pass_b: alu = in.op_b;
			default:    alu = in.op_a + in.op_b;
		endcase
	end

	// predict not taken, so any taken branch or jal redirects
	assign taken = in.is_jal || (in.is_branch && ((in.op_a == in.op_b) != in.is_bne));

	assign in_ready = !out_valid || out_ready;
	assign fire = in_valid && in_ready;
	// redirect when the branch leaves for lsu_wb
	assign redirect = out_valid && out_ready && taken_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			taken_q <= 1'b0;
		end else if (fire) begin
			out_valid <= 1'b1;
			taken_q <= taken;
		end else if (out_ready) begin
			out_valid <= 1'b0;
			taken_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			out.pc <= in.pc;
			out.rd <= in.rd;
			// jal links pc plus 4
			out.result <= in.is_jal ? in.pc + 64'd4 : alu;
			out.store_data <= in.store_data;
			out.is_load <= in.is_load;
			out.is_store <= in.is_store;
			out.writes_rd <= in.writes_rd;
			redirect_pc <= in.pc + in.imm;
		end
	end

endmodule

/* cpu_decode.sv */
module cpu_decode (
	input  logic                     clk,
	input  logic                     reset,
	input  cpu_pkg::if_id_t          in,
	input  logic                     in_valid,
	output logic                     in_ready,
	output logic [4:0]               rs1,
	output logic [4:0]               rs2,
	input  logic [cpu_pkg::xlen-1:0] rdata1,
	input  logic [cpu_pkg::xlen-1:0] rdata2,
	input  cpu_pkg::retire_t         retire,
	input  logic                     flush,
	output cpu_pkg::id_ex_t          out,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import cpu_pkg::*;

	inst_u           ins;
	id_ex_t          d;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic            uses_rs1;
	logic            uses_rs2;
	logic            hazard;
	logic            fire;
	logic            valid_q;
	logic [31:0]     busy;
	logic [31:0]     busy_next;

	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
		case (f3)
			f3_add:  return sub ? alu_sub : alu_add;
			f3_slt:  return alu_slt;
			f3_xor:  return alu_xor;
			f3_or:   return alu_or;
			f3_and:  return alu_and;
			default: return alu_add;
		endcase
	endfunction

	assign ins = in.inst;
	assign rs1 = ins.r_fmt.rs1;
	assign rs2 = ins.r_fmt.rs2;

	//********************************************************************
	// immediates, sign extended from each view
	//********************************************************************

	assign imm_i = {{52{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
	assign imm_s = {{52{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
	assign imm_b = {{52{ins.b_fmt.imm_12}}, ins.b_fmt.imm_11, ins.b_fmt.imm_10_5,
		ins.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {{32{ins.u_fmt.imm[19]}}, ins.u_fmt.imm, 12'b0};
	assign imm_j = {{44{ins.j_fmt.imm_20}}, ins.j_fmt.imm_19_12, ins.j_fmt.imm_11,
		ins.j_fmt.imm_10_1, 1'b0};

	// control decode, unknown opcodes pass as nop
	always_comb begin
		d = '0;
		d.pc = in.pc;
		d.rd = ins.r_fmt.rd;
		d.op_a = rdata1;
		d.op_b = rdata2;
		d.store_data = rdata2;
		d.alu_op = alu_add;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (ins.r_fmt.opcode)
			opc_op: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				d.writes_rd = 1'b1;
				d.alu_op = alu_sel(ins.r_fmt.funct3, ins.r_fmt.funct7 == f7_sub);
			end
			opc_op_imm: begin
				uses_rs1 = 1'b1;
				d.writes_rd = 1'b1;
				d.imm = imm_i;
				d.op_b = imm_i;
				d.alu_op = alu_sel(ins.i_fmt.funct3, 1'b0);
			end
			opc_lui: begin
				d.rd = ins.u_fmt.rd;
				d.writes_rd = 1'b1;
				d.imm = imm_u;
				d.op_b = imm_u;
				d.alu_op = alu_pass_b;
			end
			opc_branch: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				d.imm = imm_b;
				d.is_branch = ins.b_fmt.funct3 == f3_beq || ins.b_fmt.funct3 == f3_bne;
				d.is_bne = ins.b_fmt.funct3 == f3_bne;
			end
			opc_jal: begin
				d.rd = ins.j_fmt.rd;
				d.writes_rd = 1'b1;
				d.imm = imm_j;
				d.is_jal = 1'b1;
			end
			opc_load: begin
				uses_rs1 = 1'b1;
				d.writes_rd = 1'b1;
				d.imm = imm_i;
				d.op_b = imm_i;
				d.is_load = 1'b1;
			end
			opc_store: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				d.imm = imm_s;
				d.op_b = imm_s;
				d.is_store = 1'b1;
			end
			default: ;
		endcase
		// x0 target never marks the scoreboard
		d.writes_rd = d.writes_rd && d.rd != 5'd0;
	end

	//********************************************************************
	// scoreboard interlock
	//********************************************************************

	assign hazard = (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2])
		|| (d.writes_rd && busy[d.rd]);
	assign in_ready = !hazard && (!valid_q || out_ready);
	assign fire = in_valid && in_ready;
	// nothing moves to execute while a redirect is out
	assign out_valid = valid_q && !flush;

	always_comb begin
		busy_next = busy;
		if (retire.valid && retire.wen) begin
			busy_next[retire.rd] = 1'b0;
		end
		// dropped instruction gives its bit back
		if (flush && valid_q && out.writes_rd) begin
			busy_next[out.rd] = 1'b0;
		end
		if (fire && !flush && d.writes_rd) begin
			busy_next[d.rd] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			busy <= '0;
		end else begin
			busy <= busy_next;
			if (flush) begin
				valid_q <= 1'b0;
			end else if (fire) begin
				valid_q <= 1'b1;
			end else if (out_ready) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			out <= d;
		end
	end

endmodule

/* cpu_fetch.sv */
module cpu_fetch (
	input  logic                     clk,
	input  logic                     reset,
	output cpu_pkg::mem_req_t        req,
	input  cpu_pkg::mem_resp_t       resp,
	input  logic                     grant,
	input  logic                     redirect,
	input  logic [cpu_pkg::xlen-1:0] redirect_pc,
	output cpu_pkg::if_id_t          out,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [cpu_pkg::xlen-1:0] pc
);
	import cpu_pkg::*;

	logic [xlen-1:0] pc_q;
	// granted, response due this cycle
	logic            wait_q;
	// in-flight response belongs to the old path
	logic            stale_q;

	assign pc = pc_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= reset_pc;
			req.valid <= 1'b0;
			wait_q <= 1'b0;
			stale_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			// request held until the arbiter grants it
			if (req.valid && grant) begin
				req.valid <= 1'b0;
				wait_q <= 1'b1;
			end
			if (wait_q && resp.valid) begin
				wait_q <= 1'b0;
			end
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if (redirect) begin
				// drop the buffer, anything still out comes back stale
				pc_q <= redirect_pc;
				out_valid <= 1'b0;
				stale_q <= req.valid;
			end else begin
				if (wait_q && resp.valid) begin
					if (stale_q) begin
						stale_q <= 1'b0;
					end else begin
						// pc bit 2 picks the half of the word
						out_valid <= 1'b1;
						out.pc <= pc_q;
						out.inst <= pc_q[2] ? resp.rdata[63:32] : resp.rdata[31:0];
						pc_q <= pc_q + 64'd4;
					end
				end
				// one fetch at a time, only when the buffer frees up
				if (!req.valid && !wait_q && (!out_valid || out_ready)) begin
					req.valid <= 1'b1;
					req.write <= 1'b0;
					req.addr <= pc_q[mem_aw+2:3];
					req.wdata <= '0;
				end
			end
		end
	end

endmodule

/* cpu_regfile.sv */
module cpu_regfile (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [4:0]               rs1,
	input  logic [4:0]               rs2,
	output logic [cpu_pkg::xlen-1:0] rdata1,
	output logic [cpu_pkg::xlen-1:0] rdata2,
	input  cpu_pkg::retire_t         wr
);
	import cpu_pkg::*;

	logic [xlen-1:0] regs [32];

	// one write port, fed by the retire record
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.wen && wr.rd != 5'd0) begin
			regs[wr.rd] <= wr.wdata;
		end
	end

	// async reads, x0 hardwired
	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

	//********************************************************************
	// machine sizes
	//********************************************************************

	localparam int xlen = 64;
	// depth of the shared sram in 64-bit words
	localparam int mem_words = 1024;
	// word index width into the sram
	localparam int mem_aw = $clog2(mem_words);
	localparam logic [xlen-1:0] reset_pc = '0;

	// major opcodes, rv64i subset
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;

	// alu funct3
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	// branch funct3
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	// funct7 of sub, add otherwise
	localparam logic [6:0] f7_sub = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	//********************************************************************
	// instruction word, one view per encoding format
	//********************************************************************

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		// branch offset bits are scattered
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_u;

	//********************************************************************
	// stage links and memory port
	//********************************************************************

	typedef struct packed {
		logic [xlen-1:0] pc;
		inst_u           inst;
	} if_id_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		logic [xlen-1:0] op_a;
		// rs2 or immediate
		logic [xlen-1:0] op_b;
		logic [xlen-1:0] store_data;
		logic [xlen-1:0] imm;
		alu_op_t         alu_op;
		logic            is_branch;
		logic            is_bne;
		logic            is_jal;
		logic            is_load;
		logic            is_store;
		logic            writes_rd;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		// alu value, link address or memory address
		logic [xlen-1:0] result;
		logic [xlen-1:0] store_data;
		logic            is_load;
		logic            is_store;
		logic            writes_rd;
	} ex_mem_t;

	typedef struct packed {
		logic              valid;
		logic              write;
		logic [mem_aw-1:0] addr;
		logic [xlen-1:0]   wdata;
	} mem_req_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] rdata;
	} mem_resp_t;

	// commit record, also the register file write port
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		logic [xlen-1:0] wdata;
		logic            wen;
	} retire_t;

endpackage
